//--- hdl/bank_ram.sv
// single write port bank
// with one read copy per read port.
module bank_ram (
    input  logic                                clk,
    input  logic                                we,
    input  logic [mbram_pkg::index_bit_size-1:0] wa,
    input  logic [mbram_pkg::entry_bit_size-1:0] wv,
    input  logic [mbram_pkg::index_bit_size-1:0] ra [mbram_pkg::read_num],
    output logic [mbram_pkg::entry_bit_size-1:0] rv [mbram_pkg::read_num]
);

    // distributed storage, contents undefined until written.
    logic [mbram_pkg::entry_bit_size-1:0] mem [mbram_pkg::entry_num];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wv;
        end
    end

    // one asynchronous read copy per read port.
    always_comb begin
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            rv[r] = mem[ra[r]];  // old data on a same cycle write.
        end
    end

endmodule

//--- hdl/lvt_table.sv
// live value table
// records which bank holds the latest word of each address.
module lvt_table (
    input  logic                                clk,
    input  logic                                we  [mbram_pkg::write_num],
    input  logic [mbram_pkg::index_bit_size-1:0] wa  [mbram_pkg::write_num],
    input  logic [mbram_pkg::index_bit_size-1:0] ra  [mbram_pkg::read_num],
    output logic [mbram_pkg::port_bit_size-1:0]  sel [mbram_pkg::read_num]
);

    // one bank index per address.
    logic [mbram_pkg::port_bit_size-1:0] lvt [mbram_pkg::entry_num];

    // later loop iterations override earlier ones,
    // so the highest enabled port wins a collision.
    always_ff @(posedge clk) begin
        for (int i = 0; i < mbram_pkg::write_num; i++) begin
            if (we[i]) begin
                lvt[wa[i]] <= mbram_pkg::port_bit_size'(i);
            end
        end
    end

    always_comb begin
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            sel[r] = lvt[ra[r]];
        end
    end

    // a colliding write must never leave the lower port recorded.
    for (genvar i = 0; i < mbram_pkg::write_num; i++) begin : g_lo
        for (genvar j = i + 1; j < mbram_pkg::write_num; j++) begin : g_hi
            a_collision_high_wins: assert property (
                @(posedge clk)
                we[i] && we[j] && (wa[i] == wa[j])
                |=> lvt[$past(wa[j])] != mbram_pkg::port_bit_size'(i)
            ) else $error("lvt kept port %0d after collision with port %0d", i, j);
        end
    end

endmodule

//--- hdl/mbram_pkg.sv
// multi-ported ram geometry
// and serial frame layout.
package mbram_pkg;

    // memory geometry.
    localparam int entry_num      = 16;
    localparam int entry_bit_size = 8;
    localparam int read_num       = 2;
    localparam int write_num      = 2;

    localparam int index_bit_size = $clog2(entry_num);
    localparam int port_bit_size  = $clog2(write_num);  // width of a bank select.

    // frame field offsets, counted from shift bit 0.
    // read addresses sit lowest, write data highest.
    localparam int ra_offset = 0;
    localparam int we_offset = ra_offset + read_num * index_bit_size;
    localparam int wa_offset = we_offset + write_num;
    localparam int wv_offset = wa_offset + write_num * index_bit_size;

    // whole frame length, 34 bits for the default geometry.
    localparam int frame_bit_size = wv_offset + write_num * entry_bit_size;

endpackage

//--- hdl/multi_bank_ram.sv
// multi-ported distributed ram
// one bank per write port, resolved by a live value table.
module multi_bank_ram (
    input  logic                                clk,
    input  logic                                we [mbram_pkg::write_num],
    input  logic [mbram_pkg::index_bit_size-1:0] wa [mbram_pkg::write_num],
    input  logic [mbram_pkg::entry_bit_size-1:0] wv [mbram_pkg::write_num],
    input  logic [mbram_pkg::index_bit_size-1:0] ra [mbram_pkg::read_num],
    output logic [mbram_pkg::entry_bit_size-1:0] rv [mbram_pkg::read_num]
);

    // bank_rv[bank][read port].
    logic [mbram_pkg::entry_bit_size-1:0] bank_rv [mbram_pkg::write_num][mbram_pkg::read_num];

    // bank chosen per read port.
    logic [mbram_pkg::port_bit_size-1:0] sel [mbram_pkg::read_num];

    // each bank sees only its own write port but every read address.
    for (genvar b = 0; b < mbram_pkg::write_num; b++) begin : g_bank
        bank_ram i_bank (
            .clk (clk),
            .we  (we[b]),
            .wa  (wa[b]),
            .wv  (wv[b]),
            .ra  (ra),
            .rv  (bank_rv[b])
        );
    end

    lvt_table i_lvt (
        .clk (clk),
        .we  (we),
        .wa  (wa),
        .ra  (ra),
        .sel (sel)
    );

    // read multiplexers.
    always_comb begin
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            rv[r] = bank_rv[sel[r]][r];
        end
    end

    // unwritten entries give an unknown select, which is not an error.
    for (genvar r = 0; r < mbram_pkg::read_num; r++) begin : g_sel_chk
        a_sel_in_range: assert property (
            @(posedge clk)
            !$isunknown(sel[r]) |-> (int'(sel[r]) < mbram_pkg::write_num)
        ) else $error("read port %0d selects missing bank %0d", r, sel[r]);
    end

endmodule

//--- hdl/ram_test_top.sv
// ram test top
// serial harness around the multi-ported ram.
module ram_test_top (
    input  logic clk,
    input  logic rst,
    input  logic ibit,
    output logic obit
);

    // port fields from the harness.
    logic                                we [mbram_pkg::write_num];
    logic [mbram_pkg::index_bit_size-1:0] wa [mbram_pkg::write_num];
    logic [mbram_pkg::entry_bit_size-1:0] wv [mbram_pkg::write_num];
    logic [mbram_pkg::index_bit_size-1:0] ra [mbram_pkg::read_num];

    // read data back from the ram.
    logic [mbram_pkg::entry_bit_size-1:0] rv [mbram_pkg::read_num];

    serial_harness i_harness (
        .clk  (clk),
        .rst  (rst),
        .ibit (ibit),
        .obit (obit),
        .we   (we),
        .wa   (wa),
        .wv   (wv),
        .ra   (ra),
        .rv   (rv)
    );

    multi_bank_ram i_ram (
        .clk (clk),
        .we  (we),
        .wa  (wa),
        .wv  (wv),
        .ra  (ra),
        .rv  (rv)
    );

endmodule

//--- hdl/serial_harness.sv
// serial test harness
// shifts port fields in and folds the read data to one parity bit.
module serial_harness (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ibit,
    output logic                                obit,
    output logic                                we [mbram_pkg::write_num],
    output logic [mbram_pkg::index_bit_size-1:0] wa [mbram_pkg::write_num],
    output logic [mbram_pkg::entry_bit_size-1:0] wv [mbram_pkg::write_num],
    output logic [mbram_pkg::index_bit_size-1:0] ra [mbram_pkg::read_num],
    input  logic [mbram_pkg::entry_bit_size-1:0] rv [mbram_pkg::read_num]
);

    logic [mbram_pkg::frame_bit_size-1:0] ishift;  // new bits enter at bit 0.
    logic [mbram_pkg::entry_bit_size-1:0] rv_q [mbram_pkg::read_num];

    always_ff @(posedge clk) begin
        if (rst) begin
            ishift <= '0;
        end else begin
            ishift <= {ishift[mbram_pkg::frame_bit_size-2:0], ibit};
        end
    end

    // field registers, reloaded from the shift register every cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < mbram_pkg::read_num; r++) begin
                ra[r] <= '0;
            end
            for (int w = 0; w < mbram_pkg::write_num; w++) begin
                we[w] <= 1'b0;
                wa[w] <= '0;
                wv[w] <= '0;
            end
        end else begin
            for (int r = 0; r < mbram_pkg::read_num; r++) begin
                ra[r] <= ishift[mbram_pkg::ra_offset + r * mbram_pkg::index_bit_size
                                +: mbram_pkg::index_bit_size];
            end
            for (int w = 0; w < mbram_pkg::write_num; w++) begin
                we[w] <= ishift[mbram_pkg::we_offset + w];
                wa[w] <= ishift[mbram_pkg::wa_offset + w * mbram_pkg::index_bit_size
                                +: mbram_pkg::index_bit_size];
                wv[w] <= ishift[mbram_pkg::wv_offset + w * mbram_pkg::entry_bit_size
                                +: mbram_pkg::entry_bit_size];
            end
        end
    end

    // read data captured one cycle after the fields.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < mbram_pkg::read_num; r++) begin
                rv_q[r] <= '0;
            end
        end else begin
            for (int r = 0; r < mbram_pkg::read_num; r++) begin
                rv_q[r] <= rv[r];
            end
        end
    end

    // parity over every captured word.
    always_comb begin
        obit = 1'b0;
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            obit = obit ^ (^rv_q[r]);
        end
    end

    // no write may reach the ram in the cycle after reset.
    for (genvar w = 0; w < mbram_pkg::write_num; w++) begin : g_we_chk
        a_no_write_after_rst: assert property (
            @(posedge clk) rst |=> !we[w]
        ) else $error("write enable %0d high after reset", w);
    end

endmodule

//--- sim/ram_checker.sv
// reference model and obit checker
// for the serial ram harness.
module ram_checker (
    input  logic clk,
    input  logic rst,
    input  logic ibit,
    input  logic obit,
    output int   check_count,
    output int   error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // mirror of the harness shift register and field registers.
    logic [mbram_pkg::frame_bit_size-1:0] sh_m = '0;
    logic                                 f_we [mbram_pkg::write_num];
    logic [mbram_pkg::index_bit_size-1:0] f_wa [mbram_pkg::write_num];
    logic [mbram_pkg::entry_bit_size-1:0] f_wv [mbram_pkg::write_num];
    logic [mbram_pkg::index_bit_size-1:0] f_ra [mbram_pkg::read_num];

    // reference memory, with a flag for entries that hold a known word.
    logic [mbram_pkg::entry_bit_size-1:0] mem_m   [mbram_pkg::entry_num];
    logic                                 written [mbram_pkg::entry_num];

    logic [mbram_pkg::read_num*mbram_pkg::entry_bit_size-1:0] cap_m;  // captured reads, packed.
    logic cap_ok [mbram_pkg::read_num];
    logic armed = 1'b0;  // set by the first reset edge.
    int   checks = 0;
    int   errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    initial begin
        for (int i = 0; i < mbram_pkg::entry_num; i++) begin
            written[i] = 1'b0;
        end
        for (int w = 0; w < mbram_pkg::write_num; w++) begin
            f_we[w] = 1'b0;
        end
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            cap_ok[r] = 1'b0;
        end
    end

    // parity of every bit of the captured read words.
    function automatic logic expected_parity(
        input logic [mbram_pkg::read_num*mbram_pkg::entry_bit_size-1:0] words
    );
        logic p;
        p = 1'b0;
        for (int i = 0; i < mbram_pkg::read_num * mbram_pkg::entry_bit_size; i++) begin
            p = p ^ words[i];
        end
        return p;
    endfunction

    // steps run in pipeline order, each one on the state before this edge.
    always @(posedge clk) begin
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            if (rst) begin
                cap_m[r*mbram_pkg::entry_bit_size +: mbram_pkg::entry_bit_size] = '0;
                cap_ok[r] = 1'b1;
            end else begin
                cap_m[r*mbram_pkg::entry_bit_size +: mbram_pkg::entry_bit_size] = mem_m[f_ra[r]];
                cap_ok[r] = written[f_ra[r]];  // old word on a same cycle write.
            end
        end
        // the ram has no reset, so the old write fields still land here.
        for (int w = 0; w < mbram_pkg::write_num; w++) begin
            if (f_we[w] === 1'b1) begin
                mem_m[f_wa[w]] = f_wv[w];  // port 1 written last, so it wins.
                written[f_wa[w]] = 1'b1;
            end
        end
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            f_ra[r] = rst ? '0 : sh_m[mbram_pkg::ra_offset + r*mbram_pkg::index_bit_size
                                      +: mbram_pkg::index_bit_size];
        end
        for (int w = 0; w < mbram_pkg::write_num; w++) begin
            f_we[w] = rst ? 1'b0 : sh_m[mbram_pkg::we_offset + w];
            f_wa[w] = rst ? '0 : sh_m[mbram_pkg::wa_offset + w*mbram_pkg::index_bit_size
                                      +: mbram_pkg::index_bit_size];
            f_wv[w] = rst ? '0 : sh_m[mbram_pkg::wv_offset + w*mbram_pkg::entry_bit_size
                                      +: mbram_pkg::entry_bit_size];
        end
        sh_m = rst ? '0 : {sh_m[mbram_pkg::frame_bit_size-2:0], ibit};
        if (rst) begin
            armed = 1'b1;
        end
    end

    // obit settles after the rising edge, so it is compared on the falling one.
    always @(negedge clk) begin : compare
        logic usable;
        logic want;
        usable = armed;
        for (int r = 0; r < mbram_pkg::read_num; r++) begin
            usable = usable & cap_ok[r];
        end
        if (usable) begin
            want = expected_parity(cap_m);
            checks = checks + 1;
            if (obit !== want) begin
                errors = errors + 1;
                $display("** Error at %0d ns: obit expected %b, actual %b", $time, want, obit);
            end
        end
    end

endmodule

//--- sim/tb_ram_test_top.sv
// testbench for the serial ram harness
module tb_ram_test_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        rst;
    logic        ibit;
    logic        obit;
    int          check_count;
    int          error_count;
    int          cycle_limit = 4000;  // about 3200 cycles of tests plus margin.
    int          cycles = 0;
    logic [31:0] lcg_state = 32'd40;
    int          tests_run = 0;
    int          test_fails = 0;
    int          checks_mark = 0;
    int          errors_mark = 0;

    ram_test_top i_dut (
        .clk  (clk),
        .rst  (rst),
        .ibit (ibit),
        .obit (obit)
    );

    ram_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .ibit        (ibit),
        .obit        (obit),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // fields land at their package offsets once all bits are in.
    function automatic logic [mbram_pkg::frame_bit_size-1:0] build_frame(
        input logic [3:0] ra0, input logic [3:0] ra1, input logic we0, input logic we1,
        input logic [3:0] wa0, input logic [3:0] wa1, input logic [7:0] wv0, input logic [7:0] wv1
    );
        logic [mbram_pkg::frame_bit_size-1:0] f;
        f = '0;
        f[mbram_pkg::ra_offset +: 4]     = ra0;
        f[mbram_pkg::ra_offset + 4 +: 4] = ra1;
        f[mbram_pkg::we_offset]          = we0;
        f[mbram_pkg::we_offset + 1]      = we1;
        f[mbram_pkg::wa_offset +: 4]     = wa0;
        f[mbram_pkg::wa_offset + 4 +: 4] = wa1;
        f[mbram_pkg::wv_offset +: 8]     = wv0;
        f[mbram_pkg::wv_offset + 8 +: 8] = wv1;
        return f;
    endfunction

    task automatic shift_bit(input logic b);
        @(negedge clk);
        ibit = b;
    endtask

    task automatic send_frame(input logic [mbram_pkg::frame_bit_size-1:0] f);
        for (int i = mbram_pkg::frame_bit_size - 1; i >= 0; i--) begin
            shift_bit(f[i]);  // msb first.
        end
    endtask

    task automatic send_random(input int n);
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            shift_bit(lcg_state[16]);
        end
    endtask

    // three edges from ibit to obit, then one more for the count to settle.
    task automatic finish_test(input string name);
        int dc;
        int de;
        repeat (3) shift_bit(1'b0);
        @(posedge clk);
        dc = check_count - checks_mark;
        de = error_count - errors_mark;
        $display("test %s: %0d obit checks, %0d errors", name, dc, de);
        if (dc == 0) begin
            $display("test %s compared obit on no cycle at all", name);
            test_fails = test_fails + 1;
        end
        checks_mark = check_count;
        errors_mark = error_count;
        tests_run = tests_run + 1;
    endtask

    initial begin
        logic [7:0] d0;
        logic [7:0] d1;
        rst = 1'b1;
        ibit = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < 8; k++) begin
            lcg_state = lcg_next(lcg_state);
            d0 = lcg_state[23:16];
            lcg_state = lcg_next(lcg_state);
            d1 = lcg_state[23:16];
            send_frame(build_frame(0, 0, 1, 1, 2 * k, 2 * k + 1, d0, d1));
        end
        for (int k = 0; k < 8; k++) begin
            send_frame(build_frame(2 * k, (2 * k + 5) % 16, 0, 0, 0, 0, 0, 0));
        end
        finish_test("fill");

        send_frame(build_frame(0, 1, 1, 1, 5, 5, 8'h3c, 8'h01));  // port 1 data has odd parity.
        send_frame(build_frame(5, 4, 0, 0, 0, 0, 0, 0));
        finish_test("write collision");

        send_frame(build_frame(7, 2, 1, 0, 7, 0, 8'h81, 0));  // reads 7 while writing it.
        send_frame(build_frame(7, 2, 0, 0, 0, 0, 0, 0));
        finish_test("read under write");

        send_random(2000);
        finish_test("random stream");

        send_random(300);
        @(negedge clk);
        rst = 1'b1;
        ibit = 1'b0;
        repeat (6) @(negedge clk);
        rst = 1'b0;
        send_frame(build_frame(3, 12, 0, 0, 0, 0, 0, 0));
        send_frame(build_frame(0, 15, 0, 0, 0, 0, 0, 0));
        finish_test("reset mid-stream");

        $display("%0d tests, %0d obit checks, %0d errors, %0d tests without checks",
                 tests_run, check_count, error_count, test_fails);
        if (error_count == 0 && test_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/mbram_pkg.sv
hdl/bank_ram.sv
hdl/lvt_table.sv
hdl/multi_bank_ram.sv
hdl/serial_harness.sv
hdl/ram_test_top.sv
sim/ram_checker.sv
sim/tb_ram_test_top.sv
